/* common/conv_cfg_pkg.sv */
`default_nettype none

// Array shape and word widths of the convolution datapath
package conv_cfg_pkg;

  // Independent convolution copies, each with its own pixels and weights
  localparam int COPIES  = 2;
  localparam int GROUPS  = 2;
  localparam int MEMBERS = 2;
  localparam int UNITS   = 2;

  // Signed input words and the signed running sums
  localparam int WORD_WIDTH     = 8;
  localparam int WORD_WIDTH_ACC = 24;
  localparam int PRODUCT_WIDTH  = 2 * WORD_WIDTH;

  // One output word per copy, group, member and unit
  localparam int OUT_WORDS = COPIES * GROUPS * MEMBERS * UNITS;

  // Flattened buses, lane 0 in the low bits
  localparam int PIXELS_WIDTH   = COPIES * UNITS * WORD_WIDTH;
  localparam int WEIGHTS_WIDTH  = COPIES * GROUPS * MEMBERS * WORD_WIDTH;
  localparam int DATA_OUT_WIDTH = OUT_WORDS * WORD_WIDTH_ACC;

endpackage

`default_nettype wire

/* common/conv_user_pkg.sv */
`default_nettype none

// Sideband layout on the input and output tuser
package conv_user_pkg;

  // Input sideband is {relu, tag}
  localparam int TUSER_WIDTH_IN = 4;

  // ReLU enable, only looked at on the last beat of a packet
  localparam int USER_RELU_BIT = 3;

  // Tag sits in the low bits and is carried through unchanged
  localparam int TAG_WIDTH = 3;

  // Output sideband is just the tag
  localparam int TUSER_WIDTH_OUT = TAG_WIDTH;

endpackage

`default_nettype wire

/* common/conv_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Stream of accumulated results between the engine and the output slice
interface conv_stream_if;

  logic                                    valid;
  logic                                    ready;
  logic                                    last;
  logic [conv_user_pkg::TUSER_WIDTH_OUT-1:0] user;
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]   data;

  // Producer side
  modport src (
    output valid,
    input  ready,
    output last,
    output user,
    output data
  );

  // Consumer side
  modport snk (
    input  valid,
    output ready,
    input  last,
    input  user,
    input  data
  );

endinterface

`default_nettype wire

/* conv_engine/conv_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accumulator (
  input  logic                                                           aclk,
  input  logic                                                           rst_n,
  input  logic                                                           clken,
  input  logic                                                           in_valid,
  input  logic                                                           in_last,
  input  logic                                                           in_relu,
  input  logic [conv_user_pkg::TAG_WIDTH-1:0]                            in_tag,
  input  logic [conv_cfg_pkg::OUT_WORDS*conv_cfg_pkg::PRODUCT_WIDTH-1:0] in_products,
  output logic                                                           out_valid,
  output logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]                        out_sums,
  output logic [conv_user_pkg::TAG_WIDTH-1:0]                            out_tag
);

  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0] sums_q;
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0] sums_next;
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0] sums_clamped;
  logic                                    restart_q;
  logic                                    close_q;
  logic                                    relu_q;
  logic [conv_user_pkg::TAG_WIDTH-1:0]     tag_q;

  for (genvar k = 0; k < conv_cfg_pkg::OUT_WORDS; k++) begin : g_lane
    logic signed [conv_cfg_pkg::PRODUCT_WIDTH-1:0]  product;
    logic signed [conv_cfg_pkg::WORD_WIDTH_ACC-1:0] product_ext;
    logic signed [conv_cfg_pkg::WORD_WIDTH_ACC-1:0] sum;

    assign product     = in_products[k * conv_cfg_pkg::PRODUCT_WIDTH +: conv_cfg_pkg::PRODUCT_WIDTH];
    assign product_ext = product;
    assign sum         = sums_q[k * conv_cfg_pkg::WORD_WIDTH_ACC +: conv_cfg_pkg::WORD_WIDTH_ACC];

    // First beat of a packet overwrites whatever the previous packet left behind
    assign sums_next[k * conv_cfg_pkg::WORD_WIDTH_ACC +: conv_cfg_pkg::WORD_WIDTH_ACC] =
      restart_q ? product_ext : sum + product_ext;

    // ReLU clamps negative sums to zero
    assign sums_clamped[k * conv_cfg_pkg::WORD_WIDTH_ACC +: conv_cfg_pkg::WORD_WIDTH_ACC] =
      (relu_q && sum < 0) ? '0 : sum;
  end

  // close_q marks that sums_q now holds a finished packet, out_valid follows it
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      sums_q    <= '0;
      restart_q <= 1'b1;
      close_q   <= 1'b0;
      out_valid <= 1'b0;
    end else if (clken) begin
      close_q   <= in_valid & in_last;
      out_valid <= close_q;
      if (in_valid) begin
        sums_q    <= sums_next;
        restart_q <= in_last;
      end
    end
  end

  // Flags of the last beat, held until the result is written
  always_ff @(posedge aclk) begin
    if (clken && in_valid && in_last) begin
      relu_q <= in_relu;
      tag_q  <= in_tag;
    end
  end

  // Packets span at least two beats, so the next packet cannot disturb relu_q or tag_q here
  always_ff @(posedge aclk) begin
    if (clken && close_q) begin
      out_sums <= sums_clamped;
      out_tag  <= tag_q;
    end
  end

endmodule

`default_nettype wire

/* conv_engine/conv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_engine (
  input  logic                                     aclk,
  input  logic                                     rst_n,
  input  logic                                     clken,
  input  logic [conv_cfg_pkg::PIXELS_WIDTH-1:0]    s_data_pixels,
  input  logic [conv_cfg_pkg::WEIGHTS_WIDTH-1:0]   s_data_weights,
  input  logic                                     s_valid,
  output logic                                     s_ready,
  input  logic                                     s_last,
  input  logic [conv_user_pkg::TUSER_WIDTH_IN-1:0] s_user,
  conv_stream_if.src                               m
);

  logic [conv_cfg_pkg::OUT_WORDS*conv_cfg_pkg::PRODUCT_WIDTH-1:0] products_d;
  logic [conv_cfg_pkg::OUT_WORDS*conv_cfg_pkg::PRODUCT_WIDTH-1:0] products_q;
  logic                                     mul_valid;
  logic                                     mul_last;
  logic [conv_user_pkg::TUSER_WIDTH_IN-1:0] mul_user;
  logic                                     acc_valid;
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]  acc_sums;
  logic [conv_user_pkg::TAG_WIDTH-1:0]      acc_tag;

  // The whole engine is stalled through clken, so it also serves as the input ready
  assign s_ready = clken;

  // Every weight of a copy meets every pixel of that copy.
  // Output lane order is copy, group, member, unit with unit fastest
  for (genvar c = 0; c < conv_cfg_pkg::COPIES; c++) begin : g_copy
    for (genvar g = 0; g < conv_cfg_pkg::GROUPS; g++) begin : g_group
      for (genvar mb = 0; mb < conv_cfg_pkg::MEMBERS; mb++) begin : g_member
        for (genvar u = 0; u < conv_cfg_pkg::UNITS; u++) begin : g_unit
          assign products_d[(((c * conv_cfg_pkg::GROUPS + g) * conv_cfg_pkg::MEMBERS + mb)
                             * conv_cfg_pkg::UNITS + u) * conv_cfg_pkg::PRODUCT_WIDTH
                            +: conv_cfg_pkg::PRODUCT_WIDTH] =
            $signed(s_data_pixels[(c * conv_cfg_pkg::UNITS + u) * conv_cfg_pkg::WORD_WIDTH
                                  +: conv_cfg_pkg::WORD_WIDTH]) *
            $signed(s_data_weights[((c * conv_cfg_pkg::GROUPS + g) * conv_cfg_pkg::MEMBERS + mb)
                                   * conv_cfg_pkg::WORD_WIDTH +: conv_cfg_pkg::WORD_WIDTH]);
        end
      end
    end
  end

  // Multiply stage valid, a beat is taken on any enabled edge with s_valid high
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      mul_valid <= 1'b0;
    end else if (clken) begin
      mul_valid <= s_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (clken) begin
      products_q <= products_d;
      mul_last   <= s_last;
      mul_user   <= s_user;
    end
  end

  conv_accumulator accumulator (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .clken       (clken),
    .in_valid    (mul_valid),
    .in_last     (mul_last),
    .in_relu     (mul_user[conv_user_pkg::USER_RELU_BIT]),
    .in_tag      (mul_user[conv_user_pkg::TAG_WIDTH-1:0]),
    .in_products (products_q),
    .out_valid   (acc_valid),
    .out_sums    (acc_sums),
    .out_tag     (acc_tag)
  );

  // Each result closes exactly one packet
  assign m.valid = acc_valid;
  assign m.last  = acc_valid;
  assign m.data  = acc_sums;
  assign m.user  = acc_tag;

endmodule

`default_nettype wire

/* design/axis_output_slice.sv */
`timescale 1ns/1ps
`default_nettype none

// Single register stage between the engine and the AXI-Stream master port.
// Enough here because the engine never offers results on back-to-back cycles
module axis_output_slice (
  input  logic                                      aclk,
  input  logic                                      rst_n,
  conv_stream_if.snk                                s,
  output logic                                      m_tvalid,
  input  logic                                      m_tready,
  output logic                                      m_tlast,
  output logic [conv_user_pkg::TUSER_WIDTH_OUT-1:0] m_tuser,
  output logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]   m_tdata
);

  logic load;

  // Room is available when empty, or when the held beat leaves this cycle
  assign s.ready = !m_tvalid || m_tready;
  assign load    = s.valid && s.ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      m_tvalid <= 1'b0;
    end else if (load) begin
      m_tvalid <= 1'b1;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

  // Payload only changes on a load, so it is stable while stalled
  always_ff @(posedge aclk) begin
    if (load) begin
      m_tdata <= s.data;
      m_tuser <= s.user;
      m_tlast <= s.last;
    end
  end

endmodule

`default_nettype wire

/* design/axis_conv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_conv_engine (
  input  logic                                      aclk,
  input  logic                                      rst_n,
  input  logic                                      s_axis_tvalid,
  output logic                                      s_axis_tready,
  input  logic                                      s_axis_tlast,
  input  logic [conv_user_pkg::TUSER_WIDTH_IN-1:0]  s_axis_tuser,
  input  logic [conv_cfg_pkg::PIXELS_WIDTH-1:0]     s_axis_tdata_pixels,
  input  logic [conv_cfg_pkg::WEIGHTS_WIDTH-1:0]    s_axis_tdata_weights,
  output logic                                      m_axis_tvalid,
  input  logic                                      m_axis_tready,
  output logic                                      m_axis_tlast,
  output logic [conv_user_pkg::TUSER_WIDTH_OUT-1:0] m_axis_tuser,
  output logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]   m_axis_tdata
);

  logic valid_prev;
  logic clken;

  conv_stream_if engine_out ();

  // The slice ready drops for a cycle after it takes a result. The engine has
  // nothing valid in that cycle, so valid_prev lets it keep running instead of freezing
  assign clken = valid_prev | engine_out.ready;

  // Starts at one so the engine runs straight out of reset
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_prev <= 1'b1;
    end else begin
      valid_prev <= engine_out.valid & clken;
    end
  end

  conv_engine engine (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .clken          (clken),
    .s_data_pixels  (s_axis_tdata_pixels),
    .s_data_weights (s_axis_tdata_weights),
    .s_valid        (s_axis_tvalid),
    .s_ready        (s_axis_tready),
    .s_last         (s_axis_tlast),
    .s_user         (s_axis_tuser),
    .m              (engine_out.src)
  );

  axis_output_slice out_slice (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s        (engine_out.snk),
    .m_tvalid (m_axis_tvalid),
    .m_tready (m_axis_tready),
    .m_tlast  (m_axis_tlast),
    .m_tuser  (m_axis_tuser),
    .m_tdata  (m_axis_tdata)
  );

endmodule

`default_nettype wire

/* dv/conv_model.svh */
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// Position of an output word on m_axis_tdata, copy outermost and unit fastest
function automatic int out_lane(input int c, input int g, input int m, input int u);
  return ((c * conv_cfg_pkg::GROUPS + g) * conv_cfg_pkg::MEMBERS + m) * conv_cfg_pkg::UNITS + u;
endfunction

// Signed pixel of one copy and unit
function automatic int pixel_of(input logic [conv_cfg_pkg::PIXELS_WIDTH-1:0] pixels,
                                input int c, input int u);
  logic signed [conv_cfg_pkg::WORD_WIDTH-1:0] word;
  word = pixels[(c * conv_cfg_pkg::UNITS + u) * conv_cfg_pkg::WORD_WIDTH +: conv_cfg_pkg::WORD_WIDTH];
  return int'(word);
endfunction

// Signed weight of one copy, group and member
function automatic int weight_of(input logic [conv_cfg_pkg::WEIGHTS_WIDTH-1:0] weights,
                                 input int c, input int g, input int m);
  logic signed [conv_cfg_pkg::WORD_WIDTH-1:0] word;
  int index;
  index = (c * conv_cfg_pkg::GROUPS + g) * conv_cfg_pkg::MEMBERS + m;
  word  = weights[index * conv_cfg_pkg::WORD_WIDTH +: conv_cfg_pkg::WORD_WIDTH];
  return int'(word);
endfunction

// Expected output beat of one packet, clamped at zero when relu is set
function automatic logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0] packet_sums(
  input logic [conv_cfg_pkg::PIXELS_WIDTH-1:0]  pixels [$],
  input logic [conv_cfg_pkg::WEIGHTS_WIDTH-1:0] weights [$],
  input bit                                     relu
);
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0] packed_sums;
  int sum;
  packed_sums = '0;
  for (int c = 0; c < conv_cfg_pkg::COPIES; c++) begin
    for (int g = 0; g < conv_cfg_pkg::GROUPS; g++) begin
      for (int m = 0; m < conv_cfg_pkg::MEMBERS; m++) begin
        for (int u = 0; u < conv_cfg_pkg::UNITS; u++) begin
          sum = 0;
          foreach (pixels[b]) begin
            sum += pixel_of(pixels[b], c, u) * weight_of(weights[b], c, g, m);
          end
          if (relu && sum < 0) begin
            sum = 0;
          end
          packed_sums[out_lane(c, g, m, u) * conv_cfg_pkg::WORD_WIDTH_ACC +:
                      conv_cfg_pkg::WORD_WIDTH_ACC] = sum[conv_cfg_pkg::WORD_WIDTH_ACC-1:0];
        end
      end
    end
  end
  return packed_sums;
endfunction

// True when any output word has its sign bit set
function automatic bit has_negative(input logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0] bus);
  bit found;
  found = 1'b0;
  for (int k = 0; k < conv_cfg_pkg::OUT_WORDS; k++) begin
    if (bus[(k + 1) * conv_cfg_pkg::WORD_WIDTH_ACC - 1]) begin
      found = 1'b1;
    end
  end
  return found;
endfunction

`endif

/* dv/tb_axis_conv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axis_conv_engine;

  localparam int CLK_PERIOD        = 40;
  localparam int DRIVE_DELAY       = 2;
  localparam int RESET_CYCLES      = 16;
  localparam int MIN_BEATS         = 2;
  localparam int MAX_BEATS         = 6;
  localparam int LATENCY_PACKETS   = 20;
  localparam int RESTART_PACKETS   = 12;
  localparam int PRESSURE_PACKETS  = 40;
  localparam int TOTAL_PACKETS     = LATENCY_PACKETS + RESTART_PACKETS + PRESSURE_PACKETS;
  localparam int WATCHDOG_CYCLES   = TOTAL_PACKETS * MAX_BEATS * 20 + RESET_CYCLES;
  localparam int READY_PATTERN_LEN = 256;
  localparam bit [31:0] SEED       = 32'h7c1dc259;

  `include "conv_model.svh"

  logic                                      aclk = 1'b0;
  logic                                      rst_n;
  logic                                      s_axis_tvalid;
  logic                                      s_axis_tready;
  logic                                      s_axis_tlast;
  logic [conv_user_pkg::TUSER_WIDTH_IN-1:0]  s_axis_tuser;
  logic [conv_cfg_pkg::PIXELS_WIDTH-1:0]     s_axis_tdata_pixels;
  logic [conv_cfg_pkg::WEIGHTS_WIDTH-1:0]    s_axis_tdata_weights;
  logic                                      m_axis_tvalid;
  logic                                      m_axis_tready;
  logic                                      m_axis_tlast;
  logic [conv_user_pkg::TUSER_WIDTH_OUT-1:0] m_axis_tuser;
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]   m_axis_tdata;

  // Expected beats in packet order, and the front entry as seen at each edge
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]   exp_data_q [$];
  logic [conv_user_pkg::TAG_WIDTH-1:0]       exp_tag_q [$];
  bit                                        exp_relu_q [$];
  logic                                      head_valid = 1'b0;
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]   head_data;
  logic [conv_user_pkg::TAG_WIDTH-1:0]       head_tag;
  logic                                      head_relu;

  bit                                        ready_pattern [READY_PATTERN_LEN];
  int                                        ready_index = 0;
  bit                                        random_ready = 1'b0;
  bit                                        latency_check = 1'b0;
  logic [3:0]                                accept_hist = '0;
  logic                                      stall_prev = 1'b0;
  logic [conv_cfg_pkg::DATA_OUT_WIDTH-1:0]   held_data;
  logic [conv_user_pkg::TUSER_WIDTH_OUT-1:0] held_tag;
  logic                                      held_last;
  logic                                      out_fire;
  logic                                      out_negative;
  int                                        cycle = 0;
  int                                        packets_pushed = 0;
  int                                        packets_accepted = 0;
  int                                        outputs_seen = 0;
  int                                        check_errors = 0;
  int                                        other_errors = 0;
  string                                     test_name = "reset_state";

  axis_conv_engine uut (
    .aclk                 (aclk),
    .rst_n                (rst_n),
    .s_axis_tvalid        (s_axis_tvalid),
    .s_axis_tready        (s_axis_tready),
    .s_axis_tlast         (s_axis_tlast),
    .s_axis_tuser         (s_axis_tuser),
    .s_axis_tdata_pixels  (s_axis_tdata_pixels),
    .s_axis_tdata_weights (s_axis_tdata_weights),
    .m_axis_tvalid        (m_axis_tvalid),
    .m_axis_tready        (m_axis_tready),
    .m_axis_tlast         (m_axis_tlast),
    .m_axis_tuser         (m_axis_tuser),
    .m_axis_tdata         (m_axis_tdata)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  assign out_fire     = rst_n && m_axis_tvalid && m_axis_tready;
  assign out_negative = has_negative(m_axis_tdata);

  always @(posedge aclk) begin
    cycle <= cycle + 1;
  end

  // Last input beats, shifted so bit 3 marks an acceptance four samples back
  always @(posedge aclk) begin
    if (!rst_n) begin
      accept_hist <= '0;
    end else begin
      accept_hist <= {accept_hist[2:0], s_axis_tvalid && s_axis_tready && s_axis_tlast};
      if (s_axis_tvalid && s_axis_tready && s_axis_tlast) begin
        packets_accepted <= packets_accepted + 1;
      end
    end
  end

  always @(posedge aclk) begin
    if (out_fire) begin
      outputs_seen <= outputs_seen + 1;
      if (exp_data_q.size() != 0) begin
        void'(exp_data_q.pop_front());
        void'(exp_tag_q.pop_front());
        void'(exp_relu_q.pop_front());
      end
    end
    head_valid <= (exp_data_q.size() != 0);
    if (exp_data_q.size() != 0) begin
      head_data <= exp_data_q[0];
      head_tag  <= exp_tag_q[0];
      head_relu <= exp_relu_q[0];
    end
    stall_prev <= rst_n && m_axis_tvalid && !m_axis_tready;
    held_data  <= m_axis_tdata;
    held_tag   <= m_axis_tuser;
    held_last  <= m_axis_tlast;
  end

  reset_state: assert property (@(posedge aclk)
      (cycle >= 1 && cycle <= RESET_CYCLES + 2) |-> (!m_axis_tvalid && s_axis_tready))
    else begin
      check_errors++;
      $display("CHECK FAILED %s: expected tvalid 0 tready 1, actual tvalid %b tready %b",
               test_name, $sampled(m_axis_tvalid), $sampled(s_axis_tready));
    end

  output_expected: assert property (@(posedge aclk) disable iff (!rst_n)
      out_fire |-> head_valid)
    else begin
      other_errors++;
      $display("%s: an output beat arrived while no packet was outstanding", test_name);
    end

  sums_match: assert property (@(posedge aclk) disable iff (!rst_n)
      (out_fire && head_valid) |-> (m_axis_tdata == head_data))
    else begin
      check_errors++;
      $display("CHECK FAILED %s sums: expected %h actual %h",
               test_name, $sampled(head_data), $sampled(m_axis_tdata));
    end

  tag_match: assert property (@(posedge aclk) disable iff (!rst_n)
      (out_fire && head_valid) |-> (m_axis_tuser == head_tag))
    else begin
      check_errors++;
      $display("CHECK FAILED %s tag: expected %0d actual %0d",
               test_name, $sampled(head_tag), $sampled(m_axis_tuser));
    end

  last_set: assert property (@(posedge aclk) disable iff (!rst_n) out_fire |-> m_axis_tlast)
    else begin
      check_errors++;
      $display("CHECK FAILED %s tlast: expected 1 actual %b", test_name, $sampled(m_axis_tlast));
    end

  relu_clamped: assert property (@(posedge aclk) disable iff (!rst_n)
      (out_fire && head_valid && head_relu) |-> !out_negative)
    else begin
      check_errors++;
      $display("CHECK FAILED %s relu: expected no negative words, actual %h",
               test_name, $sampled(m_axis_tdata));
    end

  // A stalled beat keeps its payload until the sink takes it
  stable_when_stalled: assert property (@(posedge aclk) disable iff (!rst_n)
      stall_prev |-> (m_axis_tvalid && m_axis_tdata == held_data &&
                      m_axis_tuser == held_tag && m_axis_tlast == held_last))
    else begin
      check_errors++;
      $display("CHECK FAILED %s stall: expected valid 1 data %h, actual valid %b data %h",
               test_name, $sampled(held_data), $sampled(m_axis_tvalid), $sampled(m_axis_tdata));
    end

  latency_rise: assert property (@(posedge aclk) disable iff (!rst_n || !latency_check)
      accept_hist[3] |-> $rose(m_axis_tvalid))
    else begin
      check_errors++;
      $display("CHECK FAILED %s latency: expected tvalid rising 3 cycles after tlast, actual %b",
               test_name, $sampled(m_axis_tvalid));
    end

  latency_source: assert property (@(posedge aclk) disable iff (!rst_n || !latency_check)
      $rose(m_axis_tvalid) |-> accept_hist[3])
    else begin
      check_errors++;
      $display("%s: m_axis_tvalid rose without a last input beat 3 cycles before", test_name);
    end

  // Sends one packet of random beats and queues its expected result first
  task automatic send_packet(input int beats, input bit gaps);
    logic [conv_cfg_pkg::PIXELS_WIDTH-1:0]    pixels_q [$];
    logic [conv_cfg_pkg::WEIGHTS_WIDTH-1:0]   weights_q [$];
    logic [conv_user_pkg::TUSER_WIDTH_IN-1:0] last_user;
    logic [conv_user_pkg::TAG_WIDTH-1:0]      tag;
    bit                                       relu;
    int                                       idle;
    for (int b = 0; b < beats; b++) begin
      pixels_q.push_back($urandom());
      weights_q.push_back({$urandom(), $urandom()});
    end
    relu      = 1'($urandom_range(0, 1));
    tag       = 3'($urandom_range(0, 7));
    last_user = '0;
    last_user[conv_user_pkg::TAG_WIDTH-1:0]   = tag;
    last_user[conv_user_pkg::USER_RELU_BIT]   = relu;
    exp_data_q.push_back(packet_sums(pixels_q, weights_q, relu));
    exp_tag_q.push_back(tag);
    exp_relu_q.push_back(relu);
    packets_pushed++;
    for (int b = 0; b < beats; b++) begin
      if (gaps) begin
        idle = $urandom_range(0, 2);
        if (idle > 0) begin
          s_axis_tvalid = 1'b0;
          repeat (idle) @(posedge aclk);
          #DRIVE_DELAY;
        end
      end
      s_axis_tvalid        = 1'b1;
      s_axis_tlast         = (b == beats - 1);
      s_axis_tdata_pixels  = pixels_q[b];
      s_axis_tdata_weights = weights_q[b];
      // Sideband on earlier beats is noise the DUT has to ignore
      s_axis_tuser = (b == beats - 1) ? last_user : 4'($urandom());
      @(posedge aclk);
      while (!s_axis_tready) @(posedge aclk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic run_packets(input int count, input bit gaps);
    for (int p = 0; p < count; p++) begin
      send_packet($urandom_range(MIN_BEATS, MAX_BEATS), gaps);
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  // Waits for every queued packet to come out, then a few idle cycles for strays
  task automatic drain_outputs();
    while (outputs_seen < packets_pushed) @(posedge aclk);
    repeat (6) @(posedge aclk);
    #DRIVE_DELAY;
  endtask

  initial begin
    forever begin
      @(posedge aclk);
      #DRIVE_DELAY;
      if (random_ready) begin
        m_axis_tready = ready_pattern[ready_index];
        ready_index   = (ready_index + 1) % READY_PATTERN_LEN;
      end else begin
        m_axis_tready = 1'b1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("Timeout after %0d cycles: the DUT stopped moving data", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst_n                = 1'b0;
    s_axis_tvalid        = 1'b0;
    s_axis_tlast         = 1'b0;
    s_axis_tuser         = '0;
    s_axis_tdata_pixels  = '0;
    s_axis_tdata_weights = '0;
    m_axis_tready        = 1'b1;
    foreach (ready_pattern[i]) begin
      ready_pattern[i] = ($urandom_range(0, 99) < 55);
    end
    repeat (RESET_CYCLES) @(posedge aclk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    repeat (4) @(posedge aclk);
    #DRIVE_DELAY;

    test_name     = "fixed_latency";
    latency_check = 1'b1;
    run_packets(LATENCY_PACKETS, 1'b1);
    drain_outputs();

    // No idle cycles at all, so each first beat directly follows a last beat
    test_name = "accumulator_restart";
    run_packets(RESTART_PACKETS, 1'b0);
    drain_outputs();
    latency_check = 1'b0;

    test_name    = "back_pressure";
    random_ready = 1'b1;
    run_packets(PRESSURE_PACKETS, 1'b1);
    random_ready = 1'b0;
    drain_outputs();

    output_count: assert (outputs_seen == packets_accepted)
      else begin
        check_errors++;
        $display("CHECK FAILED %s output_count: expected %0d actual %0d",
                 test_name, packets_accepted, outputs_seen);
      end

    $display("Closing counts: check errors %0d, other errors %0d, packets %0d, outputs %0d",
             check_errors, other_errors, packets_pushed, outputs_seen);
    if (check_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
common/conv_cfg_pkg.sv
common/conv_user_pkg.sv
common/conv_stream_if.sv
conv_engine/conv_accumulator.sv
conv_engine/conv_engine.sv
design/axis_output_slice.sv
design/axis_conv_engine.sv
dv/tb_axis_conv_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axis_conv_engine
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard dv/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
